// File: compile.f
+incdir+dv
hw/exec_pkg.sv
hw/exec_op_if.sv
hw/exec_int_unit.sv
hw/exec_mul_unit.sv
hw/exec_shift_unit.sv
hw/exec_units.sv
hw/exec_top.sv
dv/exec_tb.sv

// File: dv/exec_tb_table.svh
`ifndef exec_tb_table_svh
`define exec_tb_table_svh

// One instruction per row with its hand-worked results
typedef struct packed {
   logic [5:0]                   opc;   // Raw opcode, octal
   logic [exec_pkg::data_w-1:0]  opa;
   logic [exec_pkg::data_w-1:0]  opb;
   logic [1:0]                   shf;   // Shift mode bits
   logic [exec_pkg::data_w-1:0]  res;   // Expected res_mx, two edges later
   logic [exec_pkg::data_w-1:0]  alu;   // Expected alu_ex, one edge later
   logic                         ill;   // Expected exc_ill
   logic                         c;     // Expected msr_c after this row
} row_t;

localparam int n_rows = 31;

localparam row_t rows [n_rows] = '{
   // Add, then add overflowing 32 bits, then addc picking up the carry
   '{6'o00, 32'h00000001, 32'h00000002, 2'd0, 32'h00000003, 32'h00000003, 1'b0, 1'b0},
   '{6'o00, 32'hffffffff, 32'h00000002, 2'd0, 32'h00000001, 32'h00000001, 1'b0, 1'b1},
   '{6'o02, 32'h00000010, 32'h00000020, 2'd0, 32'h00000031, 32'h00000031, 1'b0, 1'b0},
   // Equal operands, borrow free
   '{6'o01, 32'h12345678, 32'h12345678, 2'd0, 32'h00000000, 32'h00000000, 1'b0, 1'b1},
   // Logic ops with carry set, carry must hold
   '{6'o40, 32'hf0f00000, 32'h0000ff0f, 2'd0, 32'hf0f0ff0f, 32'hf0f0ff0f, 1'b0, 1'b1},
   '{6'o41, 32'hff00ff00, 32'h0f0f0f0f, 2'd0, 32'h0f000f00, 32'h0f000f00, 1'b0, 1'b1},
   '{6'o42, 32'ha5a5a5a5, 32'hffff0000, 2'd0, 32'h5a5aa5a5, 32'h5a5aa5a5, 1'b0, 1'b1},
   '{6'o43, 32'hffffffff, 32'h0000ffff, 2'd0, 32'hffff0000, 32'hffff0000, 1'b0, 1'b1},
   // 3 - 5 borrows, carry clear
   '{6'o01, 32'h00000005, 32'h00000003, 2'd0, 32'hfffffffe, 32'hfffffffe, 1'b0, 1'b0},
   // rsubc with carry clear gives 0x100 - 0x10 - 1
   '{6'o03, 32'h00000010, 32'h00000100, 2'd0, 32'h000000ef, 32'h000000ef, 1'b0, 1'b1},
   '{6'o01, 32'h00000001, 32'h00000010, 2'd0, 32'h0000000f, 32'h0000000f, 1'b0, 1'b1},
   // Illegal 24, then a legal multiply clears the flag
   '{6'o24, 32'hdeadbeef, 32'h12345678, 2'd0, 32'h00000000, 32'h00000000, 1'b1, 1'b1},
   '{6'o20, 32'h00010001, 32'h00010001, 2'd0, 32'h00020001, 32'h00000000, 1'b0, 1'b1},
   '{6'o33, 32'hffffffff, 32'hffffffff, 2'd0, 32'h00000000, 32'h00000000, 1'b1, 1'b1},
   '{6'o20, 32'hffffffff, 32'h00000007, 2'd0, 32'hfffffff9, 32'h00000000, 1'b0, 1'b1},  // -1 * 7
   '{6'o77, 32'h00000001, 32'h00000001, 2'd0, 32'h00000000, 32'h00000000, 1'b1, 1'b1},
   '{6'o20, 32'hfffffffe, 32'hfffffffd, 2'd0, 32'h00000006, 32'h00000000, 1'b0, 1'b1},  // -2 * -3
   '{6'o20, 32'h12345678, 32'h00000010, 2'd0, 32'h23456780, 32'h00000000, 1'b0, 1'b1},
   // Logical right by 0, 1, 31
   '{6'o21, 32'h80000001, 32'h00000000, 2'd0, 32'h80000001, 32'h00000000, 1'b0, 1'b1},
   '{6'o21, 32'h80000000, 32'h00000001, 2'd0, 32'h40000000, 32'h00000000, 1'b0, 1'b1},
   '{6'o21, 32'h80000000, 32'h0000001f, 2'd0, 32'h00000001, 32'h00000000, 1'b0, 1'b1},
   // Arithmetic right, negative operand
   '{6'o21, 32'h80000000, 32'h00000000, 2'd1, 32'h80000000, 32'h00000000, 1'b0, 1'b1},
   '{6'o21, 32'h80000000, 32'h00000001, 2'd1, 32'hc0000000, 32'h00000000, 1'b0, 1'b1},
   '{6'o21, 32'h80000000, 32'h0000001f, 2'd1, 32'hffffffff, 32'h00000000, 1'b0, 1'b1},
   // Left by 0, 1, 31
   '{6'o21, 32'h00000001, 32'h00000000, 2'd2, 32'h00000001, 32'h00000000, 1'b0, 1'b1},
   '{6'o21, 32'h00000003, 32'h00000001, 2'd2, 32'h00000006, 32'h00000000, 1'b0, 1'b1},
   '{6'o21, 32'h00000003, 32'h0000001f, 2'd2, 32'h80000000, 32'h00000000, 1'b0, 1'b1},
   '{6'o21, 32'h00000001, 32'h00000004, 2'd3, 32'h00000010, 32'h00000000, 1'b0, 1'b1},  // Spare
   // Upper opb bits ignored, amount is 4
   '{6'o21, 32'h87654321, 32'hffffffe4, 2'd1, 32'hf8765432, 32'h00000000, 1'b0, 1'b1},
   '{6'o00, 32'h7fffffff, 32'h00000001, 2'd0, 32'h80000000, 32'h80000000, 1'b0, 1'b0},
   '{6'o42, 32'h00000000, 32'h00000000, 2'd0, 32'h00000000, 32'h00000000, 1'b0, 1'b0}   // C stays 0
};

`endif

// File: dv/exec_tb.sv
`timescale 1ns/100ps

module exec_tb;

   `include "exec_tb_table.svh"

   localparam int half_per = 4;    // 8 ns clock
   localparam int wait_max = 20;   // Cycles before a wait gives up

   logic                         gclk;
   logic                         grst;
   logic                         dena;
   logic [5:0]                   opc;
   logic [exec_pkg::data_w-1:0]  opa;
   logic [exec_pkg::data_w-1:0]  opb;
   logic [1:0]                   shf;
   logic [exec_pkg::data_w-1:0]  alu_ex;
   logic [exec_pkg::data_w-1:0]  res_mx;
   logic                         msr_c;
   logic                         exc_ill;

   int      n_chk;
   int      n_err;
   int      en_cnt;      // Enabled edges seen since reset
   logic    timed_out;
   integer  seed;

   exec_top dut (
      .gclk    (gclk),
      .grst    (grst),
      .dena    (dena),
      .opc     (opc),
      .opa     (opa),
      .opb     (opb),
      .shf     (shf),
      .alu_ex  (alu_ex),
      .res_mx  (res_mx),
      .msr_c   (msr_c),
      .exc_ill (exc_ill)
   );

   initial begin
      gclk = 1'b0;
      forever #half_per gclk = ~gclk;
   end

   always @(posedge gclk) begin
      if (grst) begin
         en_cnt <= 0;
      end else if (dena) begin
         en_cnt <= en_cnt + 1;   // Edge that moves the pipeline
      end
   end

   task automatic chk_data(input string ctx, input string sig,
                           input logic [exec_pkg::data_w-1:0] got,
                           input logic [exec_pkg::data_w-1:0] exp);
      n_chk++;
      if (got !== exp) begin
         n_err++;
         $display("Fail %s %s: got %h, expected %h", ctx, sig, got, exp);
      end
   endtask

   task automatic chk_flag(input string ctx, input string sig, input logic got, input logic exp);
      n_chk++;
      if (got !== exp) begin
         n_err++;
         $display("Fail %s %s: got %h, expected %h", ctx, sig, got, exp);
      end
   endtask

   // Step until one more enabled edge has passed, sample 1 ns after it
   task automatic wait_enabled_edge();
      int target;
      int cycles;
      target = en_cnt + 1;
      cycles = 0;
      while (en_cnt < target && cycles < wait_max) begin
         @(posedge gclk);
         #1;
         cycles++;
      end
      if (en_cnt < target) begin
         timed_out = 1'b1;
         n_err++;
         $display("Timeout: no enabled clock edge within %0d cycles", wait_max);
      end
   endtask

   task automatic drive_row(input int i);
      opc  = rows[i].opc;
      opa  = rows[i].opa;
      opb  = rows[i].opb;
      shf  = rows[i].shf;
      dena = 1'b1;
   endtask

   // OR of zeros, pushes the last row through and keeps the carry
   task automatic drive_flush();
      opc  = 6'o40;
      opa  = '0;
      opb  = '0;
      shf  = 2'd0;
      dena = 1'b1;
   endtask

   // Stalled cycle with junk on the inputs
   task automatic drive_stall();
      logic [31:0] rnd;
      rnd  = $random(seed);
      opc  = rnd[5:0];
      shf  = rnd[7:6];
      opa  = $random(seed);
      opb  = $random(seed);
      dena = 1'b0;
   endtask

   task automatic check_ex(input int i, input string tag);
      string ctx;
      ctx = $sformatf("%s row %0d", tag, i);
      chk_data(ctx, "alu_ex", alu_ex, rows[i].alu);
      chk_flag(ctx, "exc_ill", exc_ill, rows[i].ill);
      chk_flag(ctx, "msr_c", msr_c, rows[i].c);
   endtask

   task automatic check_mx(input int i, input string tag);
      chk_data($sformatf("%s row %0d", tag, i), "res_mx", res_mx, rows[i].res);
   endtask

   task automatic check_reset();
      int errs0;
      errs0 = n_err;
      chk_data("reset", "alu_ex", alu_ex, '0);
      chk_data("reset", "res_mx", res_mx, '0);
      chk_flag("reset", "exc_ill", exc_ill, 1'b0);
      chk_flag("reset", "msr_c", msr_c, 1'b0);
      $display("reset test done, %0d errors", n_err - errs0);
   endtask

   // Back to back rows, dena held high
   task automatic run_table();
      int i;
      int errs0;
      errs0 = n_err;
      for (i = 0; i < n_rows && !timed_out; i++) begin
         drive_row(i);
         wait_enabled_edge();
         if (!timed_out) begin
            check_ex(i, "table");
            if (i > 0) check_mx(i - 1, "table");   // Previous row reaches memory
         end
      end
      drive_flush();
      wait_enabled_edge();
      if (!timed_out) check_mx(n_rows - 1, "table");
      $display("table test done, %0d rows, %0d errors", n_rows, n_err - errs0);
   endtask

   // Random dena-low gaps between rows, outputs must hold
   task automatic run_stall();
      int i;
      int g;
      int gap;
      int errs0;
      errs0 = n_err;
      for (i = 0; i < n_rows && !timed_out; i++) begin
         drive_row(i);
         wait_enabled_edge();
         if (!timed_out) begin
            check_ex(i, "stall");
            if (i > 0) check_mx(i - 1, "stall");
            gap = $unsigned($random(seed)) % 4;
            for (g = 0; g < gap; g++) begin
               drive_stall();
               @(posedge gclk);
               #1;
               check_ex(i, "frozen");
               if (i > 0) check_mx(i - 1, "frozen");
            end
         end
      end
      drive_flush();
      wait_enabled_edge();
      if (!timed_out) check_mx(n_rows - 1, "stall");
      dena = 1'b0;
      $display("stall test done, %0d rows, %0d errors", n_rows, n_err - errs0);
   endtask

   initial begin
      seed      = 32'h368a;
      n_chk     = 0;
      n_err     = 0;
      timed_out = 1'b0;
      grst      = 1'b1;
      dena      = 1'b0;
      opc       = 6'o00;
      opa       = '0;
      opb       = '0;
      shf       = 2'd0;
      repeat (2) @(posedge gclk);   // Reset held two cycles
      #1;
      grst = 1'b0;
      check_reset();
      run_table();
      if (!timed_out) run_stall();
      $display("%0d checks, %0d errors", n_chk, n_err);
      if (n_err == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: hw/exec_top.sv
`timescale 1ns/100ps

// Top level of the execution stage
// Plain bit vectors outside, package types inside
module exec_top #(
   parameter int MUL_EN = 1,
   parameter int SHF_EN = 1
) (
   input  logic                         gclk,
   input  logic                         grst,
   input  logic                         dena,     // Stage enable, low stalls
   input  logic [5:0]                   opc,      // Raw opcode field
   input  logic [exec_pkg::data_w-1:0]  opa,
   input  logic [exec_pkg::data_w-1:0]  opb,
   input  logic [1:0]                   shf,      // Immediate bits 10:9
   output logic [exec_pkg::data_w-1:0]  alu_ex,   // Integer result, 1 stage
   output logic [exec_pkg::data_w-1:0]  res_mx,   // Selected result, 2 stages
   output logic                         msr_c,
   output logic                         exc_ill
);

   exec_pkg::op_e   opc_t;   // Opcode as enum
   exec_pkg::shf_e  shf_t;   // Mode as enum

   // Static casts keep out-of-list codes so decode can flag them
   assign opc_t = exec_pkg::op_e'(opc);
   assign shf_t = exec_pkg::shf_e'(shf);

   exec_units #(
      .MUL_EN (MUL_EN),
      .SHF_EN (SHF_EN)
   ) u_units (
      .gclk    (gclk),
      .grst    (grst),
      .dena    (dena),
      .opc     (opc_t),
      .opa     (opa),
      .opb     (opb),
      .shf     (shf_t),
      .alu_ex  (alu_ex),
      .res_mx  (res_mx),
      .msr_c   (msr_c),
      .exc_ill (exc_ill)
   );

endmodule

// File: hw/exec_units.sv
`timescale 1ns/100ps

// Execution stage wrapper
// Holds the units, illegal opcode detect and memory-stage result select
module exec_units #(
   parameter int MUL_EN = 1,   // 0 removes the multiplier
   parameter int SHF_EN = 1    // 0 removes the shifter
) (
   input  logic                         gclk,
   input  logic                         grst,
   input  logic                         dena,
   input  exec_pkg::op_e                opc,
   input  logic [exec_pkg::data_w-1:0]  opa,
   input  logic [exec_pkg::data_w-1:0]  opb,
   input  exec_pkg::shf_e               shf,
   output logic [exec_pkg::data_w-1:0]  alu_ex,
   output logic [exec_pkg::data_w-1:0]  res_mx,
   output logic                         msr_c,
   output logic                         exc_ill
);

   exec_pkg::cls_e               cls_d;    // Decoded class
   exec_pkg::cls_e               cls_ex;   // Class at execute
   exec_pkg::cls_e               cls_mx;   // Class at memory
   logic [exec_pkg::data_w-1:0]  int_mx;
   logic [exec_pkg::data_w-1:0]  mul_mx;
   logic [exec_pkg::data_w-1:0]  shf_mx;

   exec_op_if op_bus ();

   // Fan the operands out on the bundle
   assign op_bus.opc  = opc;
   assign op_bus.opa  = opa;
   assign op_bus.opb  = opb;
   assign op_bus.shf  = shf;
   assign op_bus.dena = dena;

   exec_int_unit u_int (
      .gclk   (gclk),
      .grst   (grst),
      .op     (op_bus.unit),
      .int_ex (alu_ex),
      .int_mx (int_mx),
      .msr_c  (msr_c)
   );

   generate
      if (MUL_EN != 0) begin : g_mul
         exec_mul_unit u_mul (.gclk(gclk), .grst(grst), .op(op_bus.unit), .mul_mx(mul_mx));
      end else begin : g_no_mul
         assign mul_mx = '0;   // Never selected
      end
      if (SHF_EN != 0) begin : g_shf
         exec_shift_unit u_shf (.gclk(gclk), .grst(grst), .op(op_bus.unit), .shf_mx(shf_mx));
      end else begin : g_no_shf
         assign shf_mx = '0;
      end
   endgenerate

   // Class decode, missing units count as illegal
   always_comb begin
      case (opc)
         exec_pkg::op_add, exec_pkg::op_rsub, exec_pkg::op_addc, exec_pkg::op_rsubc,
         exec_pkg::op_or, exec_pkg::op_and, exec_pkg::op_xor, exec_pkg::op_andn:
            cls_d = exec_pkg::cls_int;
         exec_pkg::op_mul: cls_d = (MUL_EN != 0) ? exec_pkg::cls_mul : exec_pkg::cls_none;
         exec_pkg::op_bs:  cls_d = (SHF_EN != 0) ? exec_pkg::cls_shf : exec_pkg::cls_none;
         default:          cls_d = exec_pkg::cls_none;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         exc_ill <= 1'b0;
         cls_ex  <= exec_pkg::cls_none;
         cls_mx  <= exec_pkg::cls_none;
      end else if (dena) begin
         exc_ill <= (cls_d == exec_pkg::cls_none);
         cls_ex  <= cls_d;
         cls_mx  <= cls_ex;    // Lines up with the *_mx outputs
      end
   end

   // Memory stage writeback select
   always_comb begin
      case (cls_mx)
         exec_pkg::cls_int: res_mx = int_mx;
         exec_pkg::cls_mul: res_mx = mul_mx;
         exec_pkg::cls_shf: res_mx = shf_mx;
         default:           res_mx = '0;   // Illegal gives zero
      endcase
   end

endmodule

// File: hw/exec_shift_unit.sv
`timescale 1ns/100ps

// Two stage barrel shifter
module exec_shift_unit (
   input  logic                         gclk,
   input  logic                         grst,
   exec_op_if.unit                      op,
   output logic [exec_pkg::data_w-1:0]  shf_mx    // Shifted word
);

   localparam int amt_w = $clog2(exec_pkg::data_w);   // 5 bits for 32

   logic [exec_pkg::data_w-1:0]  shf_a;    // Latched operand
   logic [amt_w-1:0]             shf_n;    // Latched shift amount
   exec_pkg::shf_e               shf_m;    // Latched mode
   logic [exec_pkg::data_w-1:0]  shf_d;    // Shifted result

   always_comb begin
      case (shf_m)
         exec_pkg::shf_srl: shf_d = shf_a >> shf_n;
         exec_pkg::shf_sra: begin
            // Sign fill from bit 31
            shf_d = $unsigned($signed(shf_a) >>> shf_n);
         end
         default: shf_d = shf_a << shf_n;   // sll and the spare code
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         shf_a  <= '0;
         shf_n  <= '0;
         shf_m  <= exec_pkg::shf_srl;
         shf_mx <= '0;
      end else if (op.dena) begin
         if (op.opc == exec_pkg::op_bs) begin
            shf_a <= op.opa;
            shf_n <= op.opb[amt_w-1:0];   // Amount from opb[4:0]
            shf_m <= op.shf;
         end
         shf_mx <= shf_d;
      end
   end

endmodule

// File: hw/exec_mul_unit.sv
`timescale 1ns/100ps

// Two stage multiplier
// Operands latched at execute, product latched at memory
module exec_mul_unit (
   input  logic                         gclk,
   input  logic                         grst,
   exec_op_if.unit                      op,
   output logic [exec_pkg::data_w-1:0]  mul_mx    // Low product word
);

   logic [exec_pkg::data_w-1:0]  mul_a;    // Latched opa
   logic [exec_pkg::data_w-1:0]  mul_b;    // Latched opb
   logic [exec_pkg::data_w-1:0]  mul_prd;  // Low word only

   // Truncated to data_w by the target width
   // Same low word for signed and unsigned operands
   assign mul_prd = mul_a * mul_b;

   always_ff @(posedge gclk) begin
      if (grst) begin
         mul_a  <= '0;
         mul_b  <= '0;
         mul_mx <= '0;
      end else if (op.dena) begin
         if (op.opc == exec_pkg::op_mul) begin
            // Only load on a multiply so the array stays quiet otherwise
            mul_a <= op.opa;
            mul_b <= op.opb;
         end
         mul_mx <= mul_prd;   // Second half of the path
      end
   end

endmodule

// File: hw/exec_int_unit.sv
`timescale 1ns/100ps

// Integer unit: add and reverse subtract with optional carry in,
// plus the four logic ops. Owns the carry bit of the status register.
module exec_int_unit (
   input  logic                         gclk,
   input  logic                         grst,
   exec_op_if.unit                      op,
   output logic [exec_pkg::data_w-1:0]  int_ex,   // Execute stage result
   output logic [exec_pkg::data_w-1:0]  int_mx,   // Memory stage copy
   output logic                         msr_c     // Carry flag
);

   logic [exec_pkg::data_w-1:0]  add_a;     // A side of adder, inverted for rsub
   logic                         add_ci;    // Carry in
   logic [exec_pkg::data_w:0]    add_sum;   // Sum with carry out on top
   logic                         arith;     // One of the four adder opcodes
   logic [exec_pkg::data_w-1:0]  int_d;     // Next execute result

   // Adder operand and carry-in selection
   always_comb begin
      add_a  = op.opa;
      add_ci = 1'b0;
      arith  = 1'b1;
      case (op.opc)
         exec_pkg::op_add: begin
            add_ci = 1'b0;            // Plain add
         end
         exec_pkg::op_addc: begin
            add_ci = msr_c;           // Carry from earlier op
         end
         exec_pkg::op_rsub: begin
            add_a  = ~op.opa;         // rb + ~ra + 1
            add_ci = 1'b1;
         end
         exec_pkg::op_rsubc: begin
            add_a  = ~op.opa;
            add_ci = msr_c;           // Borrow in when carry clear
         end
         default: begin
            arith  = 1'b0;
         end
      endcase
   end

   // Single adder shared by all four arithmetic forms
   assign add_sum = {1'b0, add_a} + {1'b0, op.opb}
                  + {{exec_pkg::data_w{1'b0}}, add_ci};

   // Result mux
   always_comb begin
      case (op.opc)
         exec_pkg::op_or:   int_d = op.opa | op.opb;
         exec_pkg::op_and:  int_d = op.opa & op.opb;
         exec_pkg::op_xor:  int_d = op.opa ^ op.opb;
         exec_pkg::op_andn: int_d = op.opa & ~op.opb;
         default: begin
            // Adder result, zero for mul, shift and illegal codes
            int_d = arith ? add_sum[exec_pkg::data_w-1:0] : '0;
         end
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         int_ex <= '0;
         int_mx <= '0;
         msr_c  <= 1'b0;
      end else if (op.dena) begin
         int_ex <= int_d;
         int_mx <= int_ex;                        // Follows one stage behind
         if (arith) begin
            msr_c <= add_sum[exec_pkg::data_w];   // Logic ops keep carry
         end
      end
   end

endmodule

// File: hw/exec_op_if.sv
`timescale 1ns/100ps

// Operand bundle from the wrapper to the execution units
interface exec_op_if;

   exec_pkg::op_e                opc;   // Opcode of instruction entering execute
   logic [exec_pkg::data_w-1:0]  opa;   // First operand
   logic [exec_pkg::data_w-1:0]  opb;   // Second operand, immediate already folded in
   exec_pkg::shf_e               shf;   // Shift mode
   logic                         dena;  // Stage enable

   // Wrapper side
   modport src (
      output opc,
      output opa,
      output opb,
      output shf,
      output dena
   );

   // Unit side, read only
   modport unit (
      input opc,
      input opa,
      input opb,
      input shf,
      input dena
   );

endinterface

// File: hw/exec_pkg.sv
package exec_pkg;

   // Operand and result width
   localparam int data_w = 32;

   // Opcodes, octal as in the core's major opcode field
   typedef enum logic [5:0] {
      op_add   = 6'o00,   // rd = ra + rb
      op_rsub  = 6'o01,   // rd = rb - ra
      op_addc  = 6'o02,   // Add with carry in
      op_rsubc = 6'o03,   // Reverse subtract with carry in
      op_mul   = 6'o20,   // Low word of product
      op_bs    = 6'o21,   // Barrel shift
      op_or    = 6'o40,
      op_and   = 6'o41,
      op_xor   = 6'o42,
      op_andn  = 6'o43    // ra and not rb
   } op_e;

   // Which unit supplies the memory-stage result
   typedef enum logic [1:0] {
      cls_int  = 2'd0,
      cls_mul  = 2'd1,
      cls_shf  = 2'd2,
      cls_none = 2'd3     // Illegal or disabled unit
   } cls_e;

   // Shift mode from immediate bits 10:9
   // Code 11 is not listed and behaves as a left shift
   typedef enum logic [1:0] {
      shf_srl = 2'b00,    // Logical right
      shf_sra = 2'b01,    // Arithmetic right
      shf_sll = 2'b10     // Logical left
   } shf_e;

endpackage
